// File: coherentDCache.f
hdl/cachePkg.sv
hdl/ringPkg.sv
hdl/ringBusIf.sv
hdl/ringSnoop.sv
hdl/snoopQueue.sv
hdl/lineDirectory.sv
hdl/dataArray.sv
hdl/cacheController.sv
hdl/coherentDCache.sv
bench/clockGen.sv
bench/dCacheBench.sv

// File: runSim.sh
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f coherentDCache.f --top-module dCacheBench -o dCacheSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/dCacheSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation stopped with status $status"
  exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  exit 1
fi
exit 0

// File: bench/dCacheBench.sv
// testbench for the coherent data cache
// directed tests: read miss, read hit, write miss and hit, eviction, snoops
// ring model grants the token, collects slots and returns refill words
// memory copy and latest-value copy, watchdog, immediate checks

module dCacheBench;
  timeunit 1ns;
  timeprecision 1ps;
  import cachePkg::*;
  import ringPkg::*;

  localparam int clockPeriod = 100;
  localparam int resetCycles = 4;
  localparam int waitLimit   = 60; // cycles allowed for one handshake
  // rough test lengths in cycles
  localparam int readMissLen = 30;
  localparam int readHitLen  = 5;
  localparam int writeLen    = 35;
  localparam int evictLen    = 40;
  localparam int snoopLen    = 100;
  localparam int watchdogCycles =
    4 * (resetCycles + readMissLen + readHitLen + writeLen + evictLen + snoopLen);

  localparam coreIdT myCore    = 4'd1;
  localparam coreIdT otherCore = 4'd2;
  localparam tagT     tagA  = 21'h0_1234;
  localparam tagT     tagB  = 21'h1_0abc;
  localparam tagT     tagC  = 21'h0_0777;
  localparam tagT     tagD  = 21'h1_5555;
  localparam lineIdxT lineA = 7'h15;
  localparam lineIdxT lineB = 7'h2a;
  localparam lineIdxT lineD = 7'h40;

  logic     clock, reset;
  coreIdT   coreId, sourceIn, rdDest, dcSourceOut;
  cpuAddrT  aq;
  logic     read, selDCache, dcAcquireToken;
  dataT     wq, ringIn, rdReturn, rqDCache, dcRingOut;
  slotTypeT slotTypeIn, dcSlotTypeOut;
  logic     wrq, rwq, done, dcDriveRing, dcWantsToken;

  dataT     memModel [cpuAddrT]; // what memory holds
  dataT     latest [cpuAddrT];   // newest value the CPU must see
  dataT     slotData[$], expData[$];
  slotTypeT slotKind[$], expKind[$];
  integer   seed;

  clockGen #(.period(clockPeriod), .resetCycles(resetCycles)) clocks (.clock, .reset);

  coherentDCache #(.queueDepth(8)) dut (.*);

  function automatic cpuAddrT makeAddr(tagT tag, lineIdxT idx, wordOffT off);
    return {tag, idx, off};
  endfunction

  // bit 29 exclusive or flush, bit 28 read, then tag and line
  function automatic dataT addrSlot(logic bit29, logic isRead, tagT tag, lineIdxT idx);
    return {2'b00, bit29, isRead, tag, idx};
  endfunction

  task automatic failRun(string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp)
      else failRun($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic checkTrue(logic cond, string what);
    assert (cond) else failRun(what);
  endtask

  task automatic touchLine(tagT tag, lineIdxT idx);
    cpuAddrT addr;
    for (int k = 0; k < wordsPerLine; k++) begin
      addr = makeAddr(tag, idx, wordOffT'(k));
      if (!memModel.exists(addr)) begin
        memModel[addr] = $random(seed) ^ {1'b0, addr};
        latest[addr] = memModel[addr];
      end
    end
  endtask

  // eight write-data slots then the write-address slot
  task automatic expectLineFlush(tagT tag, lineIdxT idx, logic flushBit);
    for (int k = 0; k < wordsPerLine; k++) begin
      expData.push_back(latest[makeAddr(tag, idx, wordOffT'(k))]);
      expKind.push_back(slotWriteData);
    end
    expData.push_back(addrSlot(flushBit, 1'b0, tag, idx));
    expKind.push_back(slotAddress);
  endtask

  task automatic recordSlot();
    checkValue("dcSourceOut", 32'(dcSourceOut), 32'(myCore));
    slotData.push_back(dcRingOut);
    slotKind.push_back(dcSlotTypeOut);
  endtask

  task automatic grantAndCollect();
    int n;
    n = 0;
    slotData.delete();
    slotKind.delete();
    @(negedge clock);
    while (!dcWantsToken) begin
      checkTrue(!done, "done came while a miss was still open");
      n++;
      if (n > waitLimit) failRun("token request never came");
      @(negedge clock);
    end
    @(posedge clock);
    dcAcquireToken <= 1'b1;
    @(negedge clock);
    checkTrue(dcDriveRing, "no slot driven in the grant cycle");
    recordSlot();
    @(posedge clock);
    dcAcquireToken <= 1'b0; // token held for one cycle only
    @(negedge clock);
    n = 0;
    while (dcDriveRing) begin
      recordSlot();
      n++;
      if (n > 16) failRun("ring burst did not end");
      @(negedge clock);
    end
  endtask

  task automatic compareBurst();
    checkValue("slot count", slotData.size(), expData.size());
    foreach (expData[i]) begin
      checkValue($sformatf("dcSlotTypeOut[%0d]", i), 32'(slotKind[i]), 32'(expKind[i]));
      checkValue($sformatf("dcRingOut[%0d]", i), slotData[i], expData[i]);
    end
  endtask

  task automatic storeWriteBack(tagT tag, lineIdxT idx, int first);
    for (int k = 0; k < wordsPerLine; k++) begin
      memModel[makeAddr(tag, idx, wordOffT'(k))] = slotData[first + k];
    end
  endtask

  task automatic sendRefill(tagT tag, lineIdxT idx);
    for (int k = 0; k < wordsPerLine; k++) begin
      @(posedge clock);
      rdDest <= myCore;
      rdReturn <= memModel[makeAddr(tag, idx, wordOffT'(k))];
    end
    @(posedge clock);
    rdDest <= '0;
    rdReturn <= '0;
  endtask

  task automatic startRequest(cpuAddrT addr, logic isRead, dataT wdata);
    @(posedge clock);
    aq <= addr;
    read <= isRead;
    wq <= wdata;
    selDCache <= 1'b1;
  endtask

  task automatic waitDone(logic quiet, output int cycles);
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
      if (quiet) checkTrue(!dcWantsToken && !dcDriveRing, "ring traffic on a hit");
      if (cycles > waitLimit) failRun("done never came");
    end while (!done);
  endtask

  task automatic checkResponse(cpuAddrT addr, logic isRead, dataT wdata);
    if (isRead) begin
      checkValue("wrq", 32'(wrq), 32'd1);
      checkValue("rwq", 32'(rwq), 32'd0);
      checkValue("rqDCache", rqDCache, latest[addr]);
    end else begin
      checkValue("rwq", 32'(rwq), 32'd1);
      checkValue("wrq", 32'(wrq), 32'd0);
      latest[addr] = wdata;
    end
    @(posedge clock);
    selDCache <= 1'b0;
    @(negedge clock);
    checkValue("done", 32'(done), 32'd0); // single-cycle pulse
  endtask

  task automatic hitAccess(cpuAddrT addr, logic isRead, dataT wdata);
    int cycles;
    startRequest(addr, isRead, wdata);
    waitDone(1'b1, cycles);
    checkValue("hit latency", cycles, 2);
    checkResponse(addr, isRead, wdata);
  endtask

  task automatic missAccess(cpuAddrT addr, logic isRead, dataT wdata, logic evict, tagT oldTag);
    tagT     tag;
    lineIdxT idx;
    int      cycles;
    tag = addr[30:10];
    idx = addr[9:3];
    touchLine(tag, idx);
    expData.delete();
    expKind.delete();
    expData.push_back(addrSlot(!isRead, 1'b1, tag, idx)); // writes ask for exclusive
    expKind.push_back(slotAddress);
    if (evict) expectLineFlush(oldTag, idx, 1'b0);
    startRequest(addr, isRead, wdata);
    grantAndCollect();
    compareBurst();
    if (evict) storeWriteBack(oldTag, idx, 1);
    sendRefill(tag, idx);
    waitDone(1'b0, cycles);
    checkResponse(addr, isRead, wdata);
  endtask

  task automatic injectSnoop(dataT word);
    @(posedge clock);
    ringIn <= word;
    slotTypeIn <= slotAddress;
    sourceIn <= otherCore;
    @(posedge clock);
    ringIn <= '0;
    slotTypeIn <= slotNull;
    sourceIn <= '0;
  endtask

  task automatic testReadMiss();
    missAccess(makeAddr(tagA, lineA, 3'd2), 1'b1, '0, 1'b0, '0);
  endtask

  task automatic testReadHit();
    hitAccess(makeAddr(tagA, lineA, 3'd5), 1'b1, '0);
  endtask

  task automatic testWriteMissHit();
    missAccess(makeAddr(tagB, lineB, 3'd1), 1'b0, 32'hc0de_0001, 1'b0, '0);
    hitAccess(makeAddr(tagB, lineB, 3'd6), 1'b0, 32'hc0de_0006);
  endtask

  // dirty line B is replaced by tag C on the same index
  task automatic testEviction();
    missAccess(makeAddr(tagC, lineB, 3'd3), 1'b1, '0, 1'b1, tagB);
  endtask

  task automatic testSnoop();
    missAccess(makeAddr(tagD, lineD, 3'd4), 1'b0, 32'h5a5a_0004, 1'b0, '0);
    expData.delete();
    expKind.delete();
    expectLineFlush(tagD, lineD, 1'b1);
    injectSnoop(addrSlot(1'b0, 1'b1, tagD, lineD)); // plain read from another core
    grantAndCollect();
    compareBurst();
    storeWriteBack(tagD, lineD, 0);
    missAccess(makeAddr(tagD, lineD, 3'd0), 1'b0, 32'h5a5a_0000, 1'b0, '0);
    injectSnoop(addrSlot(1'b1, 1'b1, tagA, lineA)); // exclusive, line A is shared
    repeat (8) begin
      @(negedge clock);
      checkTrue(!dcWantsToken && !dcDriveRing, "ring output after an exclusive snoop");
    end
    missAccess(makeAddr(tagA, lineA, 3'd5), 1'b1, '0, 1'b0, '0);
  endtask

  initial begin
    #(watchdogCycles * clockPeriod);
    $display("watchdog expired before the tests finished");
    $display("*** FAILED ***");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    seed = 32'h1ff6;
    coreId <= myCore;
    aq <= '0;
    read <= 1'b0;
    wq <= '0;
    selDCache <= 1'b0;
    ringIn <= '0;
    slotTypeIn <= slotNull;
    sourceIn <= '0;
    rdReturn <= '0;
    rdDest <= '0;
    dcAcquireToken <= 1'b0;
    do @(negedge clock); while (reset);
    testReadMiss();
    testReadHit();
    testWriteMissHit();
    testEviction();
    testSnoop();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: bench/clockGen.sv
// bench clock and reset source
// clock period set by parameter, synchronous reset held for resetCycles edges

module clockGen #(
  parameter int period      = 100,
  parameter int resetCycles = 4
) (
  output logic clock,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clock);
    reset <= 1'b0; // released on a rising edge
  end

endmodule

// File: hdl/coherentDCache.sv
// coherent data cache top level
// ring bus bundling, snooper, snoop queue, directory,
// data memory and controller

module coherentDCache #(
  parameter int queueDepth = 8
) (
  input  logic               clock,
  input  logic               reset,
  input  ringPkg::coreIdT    coreId,
  input  cachePkg::cpuAddrT  aq,
  input  logic               read,
  input  cachePkg::dataT     wq,
  input  logic               selDCache,
  input  cachePkg::dataT     ringIn,
  input  ringPkg::slotTypeT  slotTypeIn,
  input  ringPkg::coreIdT    sourceIn,
  input  cachePkg::dataT     rdReturn,
  input  ringPkg::coreIdT    rdDest,
  input  logic               dcAcquireToken,
  output cachePkg::dataT     rqDCache,
  output logic               wrq,
  output logic               rwq,
  output logic               done,
  output cachePkg::dataT     dcRingOut,
  output ringPkg::slotTypeT  dcSlotTypeOut,
  output ringPkg::coreIdT    dcSourceOut,
  output logic               dcDriveRing,
  output logic               dcWantsToken
);
  import cachePkg::*;

  lineIdxT   snoopIdx, dirIdx;
  tagT       snoopTag, dirTag, dirNewTag;
  lineStateT snoopState, dirState, dirNewState;
  logic      push, pop, empty, dirWrite, memWrite, fillEn;
  dataT      pushWord, headWord, memWriteData, memReadData, fillData;
  wordAddrT  memAddr, fillAddr;

  ringBusIf ringBus ();
  assign ringBus.ringData = ringIn;
  assign ringBus.slotType = slotTypeIn;
  assign ringBus.source   = sourceIn;
  assign ringBus.rdReturn = rdReturn;
  assign ringBus.rdDest   = rdDest;

  ringSnoop snooper (
    .coreId, .ring(ringBus.snoop), .snoopTag, .snoopState, .snoopIdx, .push, .pushWord
  );

  snoopQueue #(.queueDepth(queueDepth)) snoopFifo (
    .clock, .reset, .push, .pushWord, .pop, .headWord, .empty
  );

  lineDirectory directory (
    .clock, .reset, .ctrlIdx(dirIdx), .writeEn(dirWrite), .newTag(dirNewTag),
    .newState(dirNewState), .snoopIdx, .ctrlTag(dirTag), .ctrlState(dirState),
    .snoopTag, .snoopState
  );

  dataArray dataMem (
    .clock, .addr(memAddr), .writeEn(memWrite), .writeData(memWriteData),
    .fillAddr, .fillEn, .fillData, .readData(memReadData)
  );

  cacheController controller (
    .clock, .reset, .coreId, .aq, .read, .wq, .selDCache, .ring(ringBus.controller),
    .headWord, .empty, .dirTag, .dirState, .memReadData, .dcAcquireToken,
    .pop, .dirIdx, .dirWrite, .dirNewTag, .dirNewState, .memAddr, .memWrite,
    .memWriteData, .fillAddr, .fillEn, .fillData, .rqDCache, .wrq, .rwq, .done,
    .dcRingOut, .dcSlotTypeOut, .dcSourceOut, .dcDriveRing, .dcWantsToken
  );

endmodule

// File: hdl/cacheController.sv
// cache controller FSM
// CPU hit handling, miss with optional victim eviction, refill capture
// snoop service with flush and downgrade, ring slot generation

module cacheController (
  input  logic                clock,
  input  logic                reset,
  input  ringPkg::coreIdT     coreId,
  input  cachePkg::cpuAddrT   aq,
  input  logic                read,
  input  cachePkg::dataT      wq,
  input  logic                selDCache,
  ringBusIf.controller        ring,
  input  cachePkg::dataT      headWord,
  input  logic                empty,
  input  cachePkg::tagT       dirTag,
  input  cachePkg::lineStateT dirState,
  input  cachePkg::dataT      memReadData,
  input  logic                dcAcquireToken,
  output logic                pop,
  output cachePkg::lineIdxT   dirIdx,
  output logic                dirWrite,
  output cachePkg::tagT       dirNewTag,
  output cachePkg::lineStateT dirNewState,
  output cachePkg::wordAddrT  memAddr,
  output logic                memWrite,
  output cachePkg::dataT      memWriteData,
  output cachePkg::wordAddrT  fillAddr,
  output logic                fillEn,
  output cachePkg::dataT      fillData,
  output cachePkg::dataT      rqDCache,
  output logic                wrq,
  output logic                rwq,
  output logic                done,
  output cachePkg::dataT      dcRingOut,
  output ringPkg::slotTypeT   dcSlotTypeOut,
  output ringPkg::coreIdT     dcSourceOut,
  output logic                dcDriveRing,
  output logic                dcWantsToken
);
  import cachePkg::*;
  import ringPkg::*;

  typedef enum logic [2:0] {
    idle, lookup, waitToken, sendVictim, sendWriteAddr, waitRefill, finish, flushWaitToken
  } ctrlStateT;

  ctrlStateT state;
  wordOffT   wordCnt, nextCnt;  // victim word on the ring
  wordOffT   fillCnt;           // next refill word expected
  logic      refilling, lastFill;
  logic      doFlush, snoopFlush, doneQ;
  lineIdxT   flushIdx;
  dataT      flushRequest;      // write-address slot sent after the victim
  dataT      readSlot, missWaSlot, snoopWaSlot;
  logic      cpuReq, hit, snoopTake, snoopHit, needFlush, downgrade;
  tagT       headTag;
  lineIdxT   headIdx;
  logic      headExcl;

  assign headTag  = headWord[slotLineMsb:slotTagLsb];
  assign headIdx  = headWord[slotTagLsb-1:0];
  assign headExcl = headWord[slotExclBit];

  assign cpuReq    = selDCache && !doneQ; // selDCache may linger a cycle past done
  assign snoopTake = (state == idle) && !empty; // snoops go before the CPU
  assign snoopHit  = (dirTag == headTag) && (dirState != INVALID);
  assign needFlush = snoopHit && (dirState == MODIFIED);
  assign downgrade = snoopHit && (headExcl || dirState == MODIFIED);

  assign hit = (dirTag == tagOf(aq)) &&
               (read ? (dirState != INVALID) : (dirState == MODIFIED));

  // slot words
  always_comb begin
    readSlot = '0;
    readSlot[slotLineMsb:0] = aq[30:3];
    readSlot[slotReadBit] = 1'b1;
    readSlot[slotExclBit] = !read; // writes need the only copy
    missWaSlot = '0;
    missWaSlot[slotLineMsb:slotTagLsb] = dirTag; // victim tag
    missWaSlot[slotTagLsb-1:0] = lineOf(aq);
    snoopWaSlot = '0;
    snoopWaSlot[slotLineMsb:0] = headWord[slotLineMsb:0];
    snoopWaSlot[slotFlushBit] = 1'b1;
  end

  // directory port
  assign pop         = snoopTake;
  assign dirIdx      = snoopTake ? headIdx : lineOf(aq);
  assign lastFill    = fillEn && (fillCnt == wordOffT'(wordsPerLine - 1));
  assign dirWrite    = lastFill || (snoopTake && downgrade);
  assign dirNewTag   = lastFill ? tagOf(aq) : dirTag;
  assign dirNewState = lastFill ? (read ? SHARED : MODIFIED)
                                : (headExcl ? INVALID : SHARED);

  // data memory port, flush address runs one word ahead of the ring
  assign nextCnt = wordCnt + 3'd1;
  always_comb begin
    case (state)
      idle:           memAddr = snoopTake ? {headIdx, 3'd0} : {lineOf(aq), wordOf(aq)};
      waitToken:      memAddr = {flushIdx, 3'd0};
      flushWaitToken: memAddr = {flushIdx, 2'b00, dcAcquireToken};
      sendVictim:     memAddr = {flushIdx, nextCnt};
      default:        memAddr = {lineOf(aq), wordOf(aq)};
    endcase
  end
  assign memWrite     = (state == lookup) && hit && !read;
  assign memWriteData = wq;

  // refill from the return ring
  assign fillEn   = refilling && (ring.rdDest == coreId);
  assign fillAddr = {lineOf(aq), fillCnt};
  assign fillData = ring.rdReturn;

  // CPU side
  assign done     = (state == lookup) && hit;
  assign wrq      = done && read;
  assign rwq      = done && !read;
  assign rqDCache = memReadData;

  // ring side
  assign dcWantsToken = (state == waitToken) || (state == flushWaitToken);
  assign dcDriveRing  = (dcWantsToken && dcAcquireToken) ||
                        (state == sendVictim) || (state == sendWriteAddr);
  assign dcSourceOut  = coreId;
  always_comb begin
    dcSlotTypeOut = slotNull;
    dcRingOut = '0;
    case (state)
      waitToken: begin
        dcSlotTypeOut = slotAddress;
        dcRingOut = readSlot;
      end
      flushWaitToken, sendVictim: begin
        dcSlotTypeOut = slotWriteData;
        dcRingOut = memReadData;
      end
      sendWriteAddr: begin
        dcSlotTypeOut = slotAddress;
        dcRingOut = flushRequest;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= idle;
      wordCnt    <= '0;
      doFlush    <= 1'b0;
      snoopFlush <= 1'b0;
      doneQ      <= 1'b0;
    end else begin
      doneQ <= done;
      case (state)
        idle: begin
          if (snoopTake) begin
            if (needFlush) begin
              state <= flushWaitToken;
              snoopFlush <= 1'b1;
            end
          end else if (cpuReq) begin
            state <= lookup;
          end
        end
        lookup: begin
          if (hit) begin
            state <= idle;
          end else begin
            state <= waitToken;
            doFlush <= dirState == MODIFIED;
            snoopFlush <= 1'b0;
          end
        end
        waitToken: begin
          if (dcAcquireToken) begin
            wordCnt <= '0;
            state <= doFlush ? sendVictim : waitRefill;
          end
        end
        flushWaitToken: begin
          if (dcAcquireToken) begin
            wordCnt <= 3'd1; // word 0 went out with the grant
            state <= sendVictim;
          end
        end
        sendVictim: begin
          wordCnt <= nextCnt;
          if (wordCnt == wordOffT'(wordsPerLine - 1)) state <= sendWriteAddr;
        end
        sendWriteAddr: state <= snoopFlush ? idle : waitRefill;
        waitRefill:    if (!refilling || lastFill) state <= finish;
        finish:        state <= lookup; // memory read of aq in flight
        default:       state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (snoopTake && needFlush) begin
      flushIdx <= headIdx;
      flushRequest <= snoopWaSlot;
    end else if (state == lookup && !hit) begin
      flushIdx <= lineOf(aq);
      flushRequest <= missWaSlot;
    end
  end

  // refill words may already arrive while the victim is still going out
  always_ff @(posedge clock) begin
    if (reset) begin
      refilling <= 1'b0;
      fillCnt <= '0;
    end else if (state == waitToken && dcAcquireToken) begin
      refilling <= 1'b1;
      fillCnt <= '0;
    end else if (fillEn) begin
      fillCnt <= fillCnt + 3'd1;
      if (lastFill) refilling <= 1'b0;
    end
  end

  // ring bursts start only on a grant, token request is held until granted
  assert property (@(posedge clock) disable iff (reset)
    dcDriveRing && !dcAcquireToken |-> $past(dcDriveRing))
    else $error("ring driven without a token");
  assert property (@(posedge clock) disable iff (reset)
    dcWantsToken && !dcAcquireToken |=> dcWantsToken)
    else $error("token request dropped before grant");

endmodule

// File: hdl/dataArray.sv
// cache data memory, 1024 words
// port A: registered read plus write for CPU hits and flushes
// port B: write only, refill from the return ring

module dataArray (
  input  logic              clock,
  input  cachePkg::wordAddrT addr,
  input  logic              writeEn,
  input  cachePkg::dataT    writeData,
  input  cachePkg::wordAddrT fillAddr,
  input  logic              fillEn,
  input  cachePkg::dataT    fillData,
  output cachePkg::dataT    readData
);
  import cachePkg::*;

  dataT mem [numLines * wordsPerLine];

  always_ff @(posedge clock) begin
    readData <= mem[addr]; // old data on a same-cycle write
    if (writeEn) mem[addr] <= writeData;
    if (fillEn) mem[fillAddr] <= fillData; // refill port
  end

endmodule

// File: hdl/lineDirectory.sv
// tag and line state arrays, one entry per cache line
// controller read/write port and combinational snoop read port

module lineDirectory (
  input  logic                clock,
  input  logic                reset,
  input  cachePkg::lineIdxT   ctrlIdx,
  input  logic                writeEn,
  input  cachePkg::tagT       newTag,
  input  cachePkg::lineStateT newState,
  input  cachePkg::lineIdxT   snoopIdx,
  output cachePkg::tagT       ctrlTag,
  output cachePkg::lineStateT ctrlState,
  output cachePkg::tagT       snoopTag,
  output cachePkg::lineStateT snoopState
);
  import cachePkg::*;

  tagT       tags   [numLines];
  lineStateT states [numLines];

  assign ctrlTag    = tags[ctrlIdx];
  assign ctrlState  = states[ctrlIdx];
  assign snoopTag   = tags[snoopIdx];
  assign snoopState = states[snoopIdx];

  always_ff @(posedge clock) begin
    if (writeEn) tags[ctrlIdx] <= newTag;
  end

  // all lines start out invalid
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < numLines; i++) begin
        states[i] <= INVALID;
      end
    end else if (writeEn) begin
      states[ctrlIdx] <= newState;
    end
  end

endmodule

// File: hdl/snoopQueue.sv
// circular FIFO of snooped address slot words
// head is shown whenever the queue is not empty

module snoopQueue #(
  parameter int queueDepth = 8 // power of two
) (
  input  logic           clock,
  input  logic           reset,
  input  logic           push,
  input  cachePkg::dataT pushWord,
  input  logic           pop,
  output cachePkg::dataT headWord,
  output logic           empty
);
  import cachePkg::*;

  localparam int ptrBits = $clog2(queueDepth);

  dataT               entries [queueDepth];
  logic [ptrBits:0]   wrPtr, rdPtr; // extra bit tells full from empty
  logic               full;

  assign empty    = wrPtr == rdPtr;
  assign full     = (wrPtr[ptrBits] != rdPtr[ptrBits]) &&
                    (wrPtr[ptrBits-1:0] == rdPtr[ptrBits-1:0]);
  assign headWord = entries[rdPtr[ptrBits-1:0]];

  always_ff @(posedge clock) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (push) wrPtr <= wrPtr + (ptrBits + 1)'(1);
      if (pop) rdPtr <= rdPtr + (ptrBits + 1)'(1);
    end
  end

  always_ff @(posedge clock) begin
    if (push) entries[wrPtr[ptrBits-1:0]] <= pushWord;
  end

  // snooper has no back-pressure, so overflow would lose a snoop
  assert property (@(posedge clock) disable iff (reset) !(push && full))
    else $error("snoop queue pushed while full");
  assert property (@(posedge clock) disable iff (reset) !(pop && empty))
    else $error("snoop queue popped while empty");

endmodule

// File: hdl/ringSnoop.sv
// ring snooper
// checks each foreign read slot against the directory snoop port
// and pushes matching slot words into the snoop queue

module ringSnoop (
  input  ringPkg::coreIdT     coreId,
  ringBusIf.snoop             ring,
  input  cachePkg::tagT       snoopTag,
  input  cachePkg::lineStateT snoopState,
  output cachePkg::lineIdxT   snoopIdx,
  output logic                push,
  output cachePkg::dataT      pushWord
);
  import cachePkg::*;
  import ringPkg::*;

  logic isAddr, isForeign, isRead, tagHit, stateHit;

  assign snoopIdx = ring.ringData[slotTagLsb-1:0]; // comb lookup, same cycle

  assign isAddr    = ring.slotType == slotAddress;
  assign isForeign = (ring.source != '0) && (ring.source <= coreIdT'(nCores)) &&
                     (ring.source != coreId);
  assign isRead    = ring.ringData[slotReadBit];
  assign tagHit    = snoopTag == ring.ringData[slotLineMsb:slotTagLsb];

  // exclusive reads hit any valid copy, plain reads only dirty ones
  assign stateHit = ring.ringData[slotExclBit] ? (snoopState != INVALID)
                                               : (snoopState == MODIFIED);

  assign push     = isAddr && isForeign && isRead && tagHit && stateHit;
  assign pushWord = ring.ringData;

endmodule

// File: hdl/ringBusIf.sv
// incoming ring slot plus the read-data return ring
// modports for the driving top level, the snooper and the controller

interface ringBusIf;
  import cachePkg::*;
  import ringPkg::*;

  dataT     ringData;
  slotTypeT slotType;
  coreIdT   source;
  dataT     rdReturn; // refill words from memory
  coreIdT   rdDest;   // which core the refill word is for

  modport driver(output ringData, slotType, source, rdReturn, rdDest);
  modport snoop(input ringData, slotType, source);
  modport controller(input ringData, rdReturn, rdDest);

endinterface

// File: hdl/ringPkg.sv
// ring slot type codes
// core id type and core count
// bit positions inside an address slot word

package ringPkg;

  typedef logic [3:0] slotTypeT;
  typedef logic [3:0] coreIdT;

  localparam slotTypeT slotNull      = 4'd0;
  localparam slotTypeT slotAddress   = 4'd1;
  localparam slotTypeT slotWriteData = 4'd2;

  localparam int nCores = 4; // valid sources are 1..nCores

  // address slot word
  //   [29]    read slot: exclusive request, write slot: requested flush
  //   [28]    1 for a read slot, 0 for a write slot
  //   [27:7]  tag
  //   [6:0]   line index, slots always name a whole line
  localparam int slotExclBit  = 29;
  localparam int slotFlushBit = 29;
  localparam int slotReadBit  = 28;
  localparam int slotLineMsb  = 27; // top of the line address
  localparam int slotTagLsb   = 7;  // index sits below this

endpackage

// File: hdl/cachePkg.sv
// cache geometry constants
// line state encoding
// address field types and extraction helpers

package cachePkg;

  localparam int wordsPerLine = 8;
  localparam int numLines = 128;

  typedef enum logic [1:0] {
    INVALID  = 2'd0, // line unused
    SHARED   = 2'd1, // clean copy, reads only
    MODIFIED = 2'd3  // only copy, dirty
  } lineStateT;

  typedef logic [30:0] cpuAddrT;  // word address from the CPU
  typedef logic [20:0] tagT;      // address bits 30..10
  typedef logic [6:0]  lineIdxT;  // address bits 9..3
  typedef logic [2:0]  wordOffT;  // word within the line
  typedef logic [9:0]  wordAddrT; // {line, word} into the data memory
  typedef logic [31:0] dataT;

  function automatic tagT tagOf(cpuAddrT addr);
    return addr[30:10];
  endfunction

  function automatic lineIdxT lineOf(cpuAddrT addr);
    return addr[9:3];
  endfunction

  function automatic wordOffT wordOf(cpuAddrT addr);
    return addr[2:0];
  endfunction

endpackage
